// File: Bender.yml
package:
  name: solar_tracker

sources:
  - src/tracker_pkg.sv
  - src/sweep_sequencer.sv
  - src/peak_register.sv
  - src/servo_pwm.sv
  - src/solar_tracker.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_solar_tracker.sv

// File: sim.f
+incdir+tests
src/tracker_pkg.sv
src/sweep_sequencer.sv
src/peak_register.sv
src/servo_pwm.sv
src/solar_tracker.sv
tests/tb_solar_tracker.sv

// File: src/peak_register.sv
// Peak register of the solar tracker
// Keeps the brightest light sample of a run together with the two
// servo positions where it was seen

module peak_register (
   input  logic                   clk,
   input  logic                   reset,

   // From the sequencer
   input  logic                   sweep_clear,
   input  logic                   sample_take,

   // Current sample and where it was taken
   input  tracker_pkg::sample_t   sample,
   input  tracker_pkg::position_t position_h,
   input  tracker_pkg::position_t position_v,

   // Stored maximum
   output tracker_pkg::sample_t   peak_sample,
   output tracker_pkg::position_t peak_h,
   output tracker_pkg::position_t peak_v
);

   import tracker_pkg::*;

   logic new_peak;

   // Strictly greater, so the first of equal samples stays
   assign new_peak = sample_take && (sample > peak_sample);

   ////////////////////////////////////////////////////////////
   // Maximum and its positions
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset || sweep_clear) begin
         // Empty peak, parks at the bottom if nothing beats zero
         peak_sample <= '0;
         peak_h      <= PW_MIN;
         peak_v      <= PW_MIN;
      end else if (new_peak) begin
         peak_sample <= sample;
         peak_h      <= position_h;
         peak_v      <= position_v;
      end
   end

endmodule

// File: src/servo_pwm.sv
// Servo PWM generator
// Frame of PWM_PERIOD cycles, high for as many cycles as the
// position latched at the start of the frame

module servo_pwm (
   input  logic                   clk,
   input  logic                   reset,
   input  tracker_pkg::position_t position,
   output logic                   pwm
);

   import tracker_pkg::*;

   frame_count_t frame_count;
   position_t    width;
   logic         frame_start;
   logic         high_next;

   assign frame_start = (frame_count == '0);

   // Count 0 uses the position directly, it is latched on this edge
   assign high_next = frame_start ? (position != '0) : (frame_count < width);

   ////////////////////////////////////////////////////////////
   // Frame counter and output register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         frame_count <= '0;
         pwm         <= 1'b0;
      end else begin
         if (frame_count == frame_count_t'(PWM_PERIOD - 1)) begin
            frame_count <= '0;
         end else begin
            frame_count <= frame_count + 1'b1;
         end
         pwm <= high_next;
      end
   end

   // Width held for the whole frame
   always_ff @(posedge clk) begin
      if (frame_start) begin
         width <= position;
      end
   end

endmodule

// File: src/solar_tracker.sv
// Solar tracker core
// Calibration sequencer, peak register and one PWM generator per
// servo axis, all on a single clock

module solar_tracker (
   input  logic                      clk,
   input  logic                      reset,

   // Run start and light samples
   input  logic                      start,
   input  logic                      sample_valid,
   input  tracker_pkg::sample_t      sample,

   // Servo PWM lines
   output logic                      servo_h,
   output logic                      servo_v,

   // Current and best positions
   output tracker_pkg::position_t    position_h,
   output tracker_pkg::position_t    position_v,
   output tracker_pkg::sample_t      peak_sample,
   output tracker_pkg::position_t    peak_h,
   output tracker_pkg::position_t    peak_v,

   // Status
   output tracker_pkg::sweep_state_t state,
   output logic                      busy
);

   // Sequencer to peak register
   logic sample_take;
   logic sweep_clear;

   ////////////////////////////////////////////////////////////
   // Sweep control and peak search
   ////////////////////////////////////////////////////////////

   sweep_sequencer sequencer (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .sample_valid (sample_valid),
      .peak_h       (peak_h),
      .peak_v       (peak_v),
      .position_h   (position_h),
      .position_v   (position_v),
      .sample_take  (sample_take),
      .sweep_clear  (sweep_clear),
      .state        (state),
      .busy         (busy)
   );

   peak_register peak (
      .clk         (clk),
      .reset       (reset),
      .sweep_clear (sweep_clear),
      .sample_take (sample_take),
      .sample      (sample),
      .position_h  (position_h),
      .position_v  (position_v),
      .peak_sample (peak_sample),
      .peak_h      (peak_h),
      .peak_v      (peak_v)
   );

   ////////////////////////////////////////////////////////////
   // Servo drivers
   ////////////////////////////////////////////////////////////

   // Horizontal axis
   servo_pwm pwm_h (
      .clk      (clk),
      .reset    (reset),
      .position (position_h),
      .pwm      (servo_h)
   );

   // Vertical axis
   servo_pwm pwm_v (
      .clk      (clk),
      .reset    (reset),
      .position (position_v),
      .pwm      (servo_v)
   );

endmodule

// File: src/sweep_sequencer.sv
// Calibration sequencer of the solar tracker
// Sweeps the horizontal axis, then the vertical one, one step per
// light sample, and parks both servos at the best position seen

module sweep_sequencer (
   input  logic                      clk,
   input  logic                      reset,

   // Run control and sample strobe
   input  logic                      start,
   input  logic                      sample_valid,

   // Best positions from the peak register
   input  tracker_pkg::position_t    peak_h,
   input  tracker_pkg::position_t    peak_v,

   // Commanded servo positions
   output tracker_pkg::position_t    position_h,
   output tracker_pkg::position_t    position_v,

   // Strobes to the peak register
   output logic                      sample_take,
   output logic                      sweep_clear,

   // Status
   output tracker_pkg::sweep_state_t state,
   output logic                      busy
);

   import tracker_pkg::*;

   ////////////////////////////////////////////////////////////
   // Start and sample qualification
   ////////////////////////////////////////////////////////////

   logic start_ok;
   logic sweeping;

   // New run only from rest, start is dropped mid-sweep
   assign start_ok = start && (state == idle || state == parked);

   // Only the two sweep states take samples
   assign sweeping = (state == sweep_h) || (state == sweep_v);

   // Clear the stored peak on the same edge the run begins
   assign sweep_clear = start_ok;

   // Peak register sees the sample in the cycle it arrives
   assign sample_take = sample_valid && sweeping;

   // Busy covers both sweeps and both settle cycles
   assign busy = state inside {sweep_h, settle_h, sweep_v, settle_v};

   ////////////////////////////////////////////////////////////
   // Calibration FSM with servo position registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= idle;
         position_h <= PW_MIN;
         position_v <= PW_MIN;
      end else begin
         case (state)
            // Waiting for the first run, or resting after one
            idle, parked: begin
               if (start_ok) begin
                  state      <= sweep_h;
                  position_h <= PW_MIN;
                  position_v <= PW_MIN;
               end
            end

            // Horizontal sweep, vertical held at the bottom
            sweep_h: begin
               if (sample_take) begin
                  // Last horizontal position sampled
                  if (position_h == PW_MAX) begin
                     state <= settle_h;
                  end else begin
                     position_h <= position_h + PW_STEP;
                  end
               end
            end

            // One cycle: peak_h is final by now
            settle_h: begin
               position_h <= peak_h;
               position_v <= PW_MIN;
               state      <= sweep_v;
            end

            // Vertical sweep at the best horizontal position
            sweep_v: begin
               if (sample_take) begin
                  if (position_v == PW_MAX) begin
                     state <= settle_v;
                  end else begin
                     position_v <= position_v + PW_STEP;
                  end
               end
            end

            // One cycle: move vertical to its best position
            settle_v: begin
               position_v <= peak_v;
               state      <= parked;
            end

            // Unused encodings fall back to rest
            default: begin
               state <= idle;
            end
         endcase
      end
   end

endmodule

// File: src/tracker_pkg.sv
// Solar tracker shared definitions
// Sample and servo position types, sequencer states and the
// servo range and PWM frame constants

package tracker_pkg;

   ////////////////////////////////////////////////////////////
   // Data types
   ////////////////////////////////////////////////////////////

   // Light sample from the converter
   typedef logic [11:0] sample_t;

   // Servo pulse width in clock cycles
   typedef logic [7:0] position_t;

   ////////////////////////////////////////////////////////////
   // Servo range and PWM frame
   ////////////////////////////////////////////////////////////

   // Sweep range, both axes use the same limits
   localparam position_t PW_MIN  = 8'd20;
   localparam position_t PW_MAX  = 8'd40;
   localparam position_t PW_STEP = 8'd2;

   // Frame length of the servo PWM in cycles
   localparam int PWM_PERIOD = 200;

   // Counter wide enough to cover one frame
   typedef logic [$clog2(PWM_PERIOD)-1:0] frame_count_t;

   ////////////////////////////////////////////////////////////
   // Calibration sequencer states
   ////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      idle     = 3'd0,
      sweep_h  = 3'd1,
      settle_h = 3'd2,
      sweep_v  = 3'd3,
      settle_v = 3'd4,
      parked   = 3'd5
   } sweep_state_t;

endpackage

// File: tests/tb_checks.svh
// Testbench helpers for the solar tracker
// Typed compare tasks, error counters, a linear congruential
// generator and the light profiles used as stimulus

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////////////
// Error bookkeeping
////////////////////////////////////////////////////////////

int check_count    = 0;
int mismatch_count = 0;
int failure_count  = 0;

// Failures that are not a wrong value
task automatic report_failure(input string what);
   failure_count++;
   $display("Error at time %0t: %s", $time, what);
endtask

task automatic check_sample(input string name, input sample_t actual, input sample_t expected);
   check_count++;
   if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch at time %0t: %s = %0d, expected %0d", $time, name, actual, expected);
   end
endtask

task automatic check_position(input string name, input position_t actual,
                              input position_t expected);
   check_count++;
   if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch at time %0t: %s = %0d, expected %0d", $time, name, actual, expected);
   end
endtask

task automatic check_state(input string name, input sweep_state_t actual,
                           input sweep_state_t expected);
   check_count++;
   if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch at time %0t: %s = %s (%0d), expected %s", $time, name,
               actual.name(), actual, expected.name());
   end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
   check_count++;
   if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch at time %0t: %s = %b, expected %b", $time, name, actual, expected);
   end
endtask

// Cycle counts measured on the PWM lines
task automatic check_cycles(input string name, input int actual, input int expected);
   check_count++;
   if (actual != expected) begin
      mismatch_count++;
      $display("Mismatch at time %0t: %s = %0d, expected %0d", $time, name, actual, expected);
   end
endtask

////////////////////////////////////////////////////////////
// Noise source and light model
////////////////////////////////////////////////////////////

logic [31:0] lcg_state = 32'd71;

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// Profile selectors
localparam int PROFILE_ZERO   = 0;
localparam int PROFILE_TWIN   = 1;
localparam int PROFILE_PEAK_A = 2;
localparam int PROFILE_PEAK_B = 3;

// Peak centres, well inside the range
localparam int PEAK_A_H = 32;
localparam int PEAK_A_V = 28;
localparam int PEAK_B_H = 26;
localparam int PEAK_B_V = 36;

// Twin profile, two equal maxima per axis
localparam int TWIN_H_FIRST  = 24;
localparam int TWIN_H_SECOND = 34;
localparam int TWIN_V_FIRST  = 26;
localparam int TWIN_V_SECOND = 36;

localparam int PEAK_LEVEL = 3000;
// Drop per cycle of distance, 120 per step beats the noise
localparam int FALLOFF    = 60;

function automatic int distance(input int a, input int b);
   return (a > b) ? a - b : b - a;
endfunction

// Peak falling off with city-block distance, 0..7 of noise
function automatic int peak_light(input int ch, input int cv, input int h, input int v);
   int noise;
   noise = int'(lcg_next() >> 29);
   return PEAK_LEVEL - FALLOFF * (distance(h, ch) + distance(v, cv)) + noise;
endfunction

function automatic sample_t light_model(input int profile, input position_t h,
                                        input position_t v);
   int level;
   level = 0;
   case (profile)
      PROFILE_TWIN: begin
         level = 100;
         if (int'(h) == TWIN_H_FIRST || int'(h) == TWIN_H_SECOND) level += 200;
         if (int'(v) == TWIN_V_FIRST || int'(v) == TWIN_V_SECOND) level += 200;
      end
      PROFILE_PEAK_A: level = peak_light(PEAK_A_H, PEAK_A_V, int'(h), int'(v));
      PROFILE_PEAK_B: level = peak_light(PEAK_B_H, PEAK_B_V, int'(h), int'(v));
      default:        level = 0;
   endcase
   return sample_t'(level);
endfunction

`endif

// File: tests/tb_solar_tracker.sv
// Testbench of the solar tracker core
// Directed tests for reset, sample gating, full sweeps over several
// light profiles, PWM frame timing and restart from the parked state

module tb_solar_tracker;

   import tracker_pkg::*;

   ////////////////////////////////////////////////////////////
   // Run length
   ////////////////////////////////////////////////////////////

   localparam int CLK_HALF         = 2;
   localparam int RESET_CYCLES     = 10;
   localparam int SAMPLE_GAP       = 3;
   localparam int SAMPLES_PER_AXIS = int'((PW_MAX - PW_MIN) / PW_STEP) + 1;
   localparam int PARK_WAIT        = 8;
   localparam int SWEEP_CYCLES     = 2 * SAMPLES_PER_AXIS * SAMPLE_GAP + PARK_WAIT + 4;
   localparam int SWEEP_RUNS       = 4;
   localparam int IDLE_CYCLES      = 4 * SAMPLE_GAP + 2;
   // Two lines, up to three frames each
   localparam int PWM_CYCLES       = 2 * 3 * PWM_PERIOD;
   localparam int TEST_CYCLES      = RESET_CYCLES + IDLE_CYCLES
                                     + SWEEP_RUNS * SWEEP_CYCLES + PWM_CYCLES;
   localparam int TIMEOUT_CYCLES   = 2 * TEST_CYCLES;

   // DUT inputs
   logic    clk;
   logic    reset;
   logic    start;
   logic    sample_valid;
   sample_t sample;

   // DUT outputs
   logic         servo_h;
   logic         servo_v;
   position_t    position_h;
   position_t    position_v;
   sample_t      peak_sample;
   position_t    peak_h;
   position_t    peak_v;
   sweep_state_t state;
   logic         busy;

   // Expected peak from the samples sent
   sample_t   exp_peak;
   position_t exp_peak_h;
   position_t exp_peak_v;

   int cycle_count;

   `include "tb_checks.svh"

   solar_tracker UUT (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .sample_valid (sample_valid),
      .sample       (sample),
      .servo_h      (servo_h),
      .servo_v      (servo_v),
      .position_h   (position_h),
      .position_v   (position_v),
      .peak_sample  (peak_sample),
      .peak_h       (peak_h),
      .peak_v       (peak_v),
      .state        (state),
      .busy         (busy)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // Hard limit on the whole run
   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("** FAIL **");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////

   // One strobe, then a gap; start can be pulsed inside the gap
   task automatic send_sample(input sample_t value, input logic pulse_mid);
      @(posedge clk);
      sample_valid <= 1'b1;
      sample       <= value;
      @(posedge clk);
      sample_valid <= 1'b0;
      start        <= pulse_mid;
      repeat (SAMPLE_GAP - 2) begin
         @(posedge clk);
         start <= 1'b0;
      end
   endtask

   // Ends at the falling edge after start was taken
   task automatic pulse_start();
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
   endtask

   function automatic logic servo_line(input bit vertical);
      return vertical ? servo_v : servo_h;
   endfunction

   // Skips the frame in progress and measures the next full one
   task automatic measure_frame(input bit vertical, output int high_cycles,
                                output int frame_cycles);
      high_cycles  = 0;
      frame_cycles = 0;
      @(negedge clk);
      while (servo_line(vertical) !== 1'b0) @(negedge clk);
      while (servo_line(vertical) !== 1'b1) @(negedge clk);
      while (servo_line(vertical) === 1'b1) begin
         high_cycles++;
         frame_cycles++;
         @(negedge clk);
      end
      while (servo_line(vertical) === 1'b0) begin
         frame_cycles++;
         @(negedge clk);
      end
   endtask

   // Full calibration run, checked sample by sample
   task automatic run_sweep(input int profile, input bit start_midway);
      sample_t      value;
      position_t    exp_h;
      position_t    exp_v;
      position_t    best_h;
      sweep_state_t exp_state;
      int           wait_count;
      best_h = PW_MIN;
      pulse_start();
      // Peak cleared on acceptance
      check_state("state", state, sweep_h);
      check_bit("busy", busy, 1'b1);
      check_sample("peak_sample", peak_sample, '0);
      check_position("peak_h", peak_h, PW_MIN);
      check_position("peak_v", peak_v, PW_MIN);
      exp_peak   = '0;
      exp_peak_h = PW_MIN;
      exp_peak_v = PW_MIN;
      for (int i = 0; i < 2 * SAMPLES_PER_AXIS; i++) begin
         if (i < SAMPLES_PER_AXIS) begin
            exp_state = sweep_h;
            exp_h     = position_t'(int'(PW_MIN) + i * int'(PW_STEP));
            exp_v     = PW_MIN;
         end else begin
            if (i == SAMPLES_PER_AXIS) best_h = exp_peak_h;
            exp_state = sweep_v;
            exp_h     = best_h;
            exp_v     = position_t'(int'(PW_MIN) + (i - SAMPLES_PER_AXIS) * int'(PW_STEP));
         end
         check_state("state", state, exp_state);
         check_position("position_h", position_h, exp_h);
         check_position("position_v", position_v, exp_v);
         check_bit("busy", busy, 1'b1);
         value = light_model(profile, exp_h, exp_v);
         // Strictly greater keeps the first of equals
         if (value > exp_peak) begin
            exp_peak   = value;
            exp_peak_h = exp_h;
            exp_peak_v = exp_v;
         end
         send_sample(value, start_midway && i == 4);
         @(negedge clk);
      end
      wait_count = 0;
      while (state != parked && wait_count < PARK_WAIT) begin
         @(negedge clk);
         wait_count++;
      end
      if (state != parked) begin
         report_failure("sequencer did not reach parked after the last sample");
      end
      check_bit("busy", busy, 1'b0);
      check_position("position_h", position_h, exp_peak_h);
      check_position("position_v", position_v, exp_peak_v);
      check_sample("peak_sample", peak_sample, exp_peak);
      check_position("peak_h", peak_h, exp_peak_h);
      check_position("peak_v", peak_v, exp_peak_v);
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////

   task automatic reset_state();
      repeat (RESET_CYCLES - 1) @(posedge clk);
      @(negedge clk);
      check_bit("servo_h", servo_h, 1'b0);
      check_bit("servo_v", servo_v, 1'b0);
      @(posedge clk);
      reset <= 1'b0;
      // Last cycle before the first frame
      @(negedge clk);
      check_state("state", state, idle);
      check_bit("busy", busy, 1'b0);
      check_bit("servo_h", servo_h, 1'b0);
      check_bit("servo_v", servo_v, 1'b0);
      check_position("position_h", position_h, PW_MIN);
      check_position("position_v", position_v, PW_MIN);
      check_position("peak_h", peak_h, PW_MIN);
      check_position("peak_v", peak_v, PW_MIN);
      check_sample("peak_sample", peak_sample, '0);
   endtask

   task automatic idle_samples_ignored();
      repeat (3) send_sample(12'hFFF, 1'b0);
      @(negedge clk);
      check_state("state", state, idle);
      check_sample("peak_sample", peak_sample, '0);
      check_position("position_h", position_h, PW_MIN);
      check_position("position_v", position_v, PW_MIN);
   endtask

   // Mid-sweep start pulse must be ignored
   task automatic single_peak_sweep();
      run_sweep(PROFILE_PEAK_A, 1'b1);
      check_position("position_h", position_h, position_t'(PEAK_A_H));
      check_position("position_v", position_v, position_t'(PEAK_A_V));
   endtask

   task automatic pwm_frames();
      int high_cycles;
      int frame_cycles;
      measure_frame(1'b0, high_cycles, frame_cycles);
      check_cycles("servo_h high time", high_cycles, int'(exp_peak_h));
      check_cycles("servo_h frame length", frame_cycles, PWM_PERIOD);
      measure_frame(1'b1, high_cycles, frame_cycles);
      check_cycles("servo_v high time", high_cycles, int'(exp_peak_v));
      check_cycles("servo_v frame length", frame_cycles, PWM_PERIOD);
   endtask

   task automatic zero_profile();
      run_sweep(PROFILE_ZERO, 1'b0);
      check_position("position_h", position_h, PW_MIN);
      check_position("position_v", position_v, PW_MIN);
      check_sample("peak_sample", peak_sample, '0);
   endtask

   // First maximum in sweep order wins on both axes
   task automatic twin_maxima();
      run_sweep(PROFILE_TWIN, 1'b0);
      check_position("position_h", position_h, position_t'(TWIN_H_FIRST));
      check_position("position_v", position_v, position_t'(TWIN_V_FIRST));
   endtask

   task automatic restart_sweep();
      run_sweep(PROFILE_PEAK_B, 1'b0);
      check_position("position_h", position_h, position_t'(PEAK_B_H));
      check_position("position_v", position_v, position_t'(PEAK_B_V));
   endtask

   initial begin
      reset        = 1'b1;
      start        = 1'b0;
      sample_valid = 1'b0;
      sample       = '0;
      reset_state();
      idle_samples_ignored();
      single_peak_sweep();
      pwm_frames();
      zero_profile();
      twin_maxima();
      restart_sweep();
      $display("Checks: %0d, mismatches: %0d, other errors: %0d",
               check_count, mismatch_count, failure_count);
      if (mismatch_count == 0 && failure_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule
